// ==== build.f ====
+incdir+src
src/duck_hunt_pkg.sv
src/trigger_tracker.sv
src/hit_detector.sv
src/hud_overlay.sv
src/pixel_compositor.sv
src/color_mapper.sv
verif/clock_gen.sv
verif/tb_color_mapper.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the color_mapper testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_color_mapper -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
	exit 0
fi
exit 1

// ==== src/color_mapper.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module color_mapper (
	input  wire logic                       vga_clk,
	input  wire logic                       Reset,
	input  wire duck_hunt_pkg::beam_t       beam,
	input  wire duck_hunt_pkg::cursor_t     cursor,
	input  wire logic [7:0]                 mouse_buttons,
	input  wire duck_hunt_pkg::duck_pos_t   duck,
	input  wire logic [`NUM_DUCKS-1:0]      duck_killed,
	input  wire duck_hunt_pkg::game_flags_t flags,
	output duck_hunt_pkg::rgb_t             pixel,
	output logic [1:0]                      count,
	output logic [9:0]                      ledr,
	output logic                            start_game_signal,
	output logic                            duck_kill_signal
);

	logic                       shot_on;
	logic                       square_on;
	duck_hunt_pkg::tally_mark_e tally;

	// ------------------------------
	// trigger, flash and bullets
	trigger_tracker i_trigger_tracker (
		.vga_clk       (vga_clk),
		.Reset         (Reset),
		.mouse_buttons (mouse_buttons),
		.shoot_enable  (flags.shoot_enable),
		.kill_pending  (flags.kill_pending),
		.out_of_shots  (flags.out_of_shots),
		.shot_on       (shot_on),
		.count         (count),
		.ledr          (ledr)
	);

	hit_detector i_hit_detector (
		.vga_clk           (vga_clk),
		.Reset             (Reset),
		.cursor            (cursor),
		.duck              (duck),
		.mouse_buttons     (mouse_buttons),
		.in_game           (flags.in_game),
		.shot_on           (shot_on),
		.start_game_signal (start_game_signal),
		.duck_kill_signal  (duck_kill_signal)
	);

	// ------------------------------
	// drawing
	hud_overlay i_hud_overlay (
		.beam        (beam),
		.count       (count),
		.duck_killed (duck_killed),
		.in_game     (flags.in_game),
		.square_on   (square_on),
		.tally       (tally)
	);

	pixel_compositor i_pixel_compositor (
		.vga_clk   (vga_clk),
		.Reset     (Reset),
		.beam      (beam),
		.cursor    (cursor),
		.shot_on   (shot_on),
		.square_on (square_on),
		.tally     (tally),
		.pixel     (pixel)
	);

endmodule

`default_nettype wire

// ==== src/duck_hunt_macros.svh ====
`ifndef DUCK_HUNT_MACROS_SVH
`define DUCK_HUNT_MACROS_SVH

// ------------------------------
// datapath widths
`define COORD_W            10
`define COLOR_W            4
`define HOLD_CNT_W         20       // trigger hold counter

// ------------------------------
// trigger and shot flash
`define SHOT_FLASH_CYCLES  1000
`define MAX_SHOTS          3
`define FLASH_HALF         25       // box side is 2*25+1
`define BTN_LEFT           8'd1
`define BTN_RIGHT          8'd2

// start button on the main menu, bounds inclusive
`define MENU_BTN_X0        200
`define MENU_BTN_X1        300
`define MENU_BTN_Y0        250
`define MENU_BTN_Y1        300

// duck hit box, relative to duck position
`define HIT_MARGIN_LO      18
`define HIT_MARGIN_HI      83

// ------------------------------
// shots-left squares
`define SQ_Y0              418
`define SQ_Y1              430
`define SQ1_X0             68
`define SQ2_X0             85
`define SQ3_X0             102
`define SQ_W               9

// tally row of discs
`define TALLY_X0           228
`define TALLY_Y            424
`define TALLY_PITCH        22
`define TALLY_R2           36       // radius 6, squared
`define TALLY_BAND_X0      200
`define TALLY_BAND_X1      433
`define TALLY_BAND_Y0      417
`define TALLY_BAND_Y1      431
`define NUM_DUCKS          10

// colours as {r,g,b}
`define COL_WHITE          12'hFFF
`define COL_SHOT           12'hAAA
`define COL_HIT            12'hD00
`define COL_BG             12'hBBB

`endif

// ==== src/duck_hunt_pkg.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

package duck_hunt_pkg;

	// ------------------------------
	// raster and pointer
	typedef struct packed {
		logic [`COORD_W-1:0] draw_x;
		logic [`COORD_W-1:0] draw_y;
		logic                visible;   // low while blanking
	} beam_t;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
		logic [`COORD_W-1:0] size;      // diamond half diagonal
	} cursor_t;

	// duck can sit partly off screen
	typedef struct packed {
		logic signed [`COORD_W:0] x;
		logic signed [`COORD_W:0] y;
	} duck_pos_t;

	// ------------------------------
	// game state from the game FSM
	typedef struct packed {
		logic in_game;
		logic kill_pending;             // clears the bullet count
		logic shoot_enable;
		logic out_of_shots;
	} game_flags_t;

	typedef struct packed {
		logic [`COLOR_W-1:0] red;
		logic [`COLOR_W-1:0] green;
		logic [`COLOR_W-1:0] blue;
	} rgb_t;

	// colour of one tally disc
	typedef enum logic [1:0] {
		TALLY_NONE = 2'd0,
		TALLY_MISS = 2'd1,              // white
		TALLY_HIT  = 2'd2               // red
	} tally_mark_e;

endpackage

`default_nettype wire

// ==== src/hit_detector.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module hit_detector (
	input  wire logic                     vga_clk,
	input  wire logic                     Reset,
	input  wire duck_hunt_pkg::cursor_t   cursor,
	input  wire duck_hunt_pkg::duck_pos_t duck,
	input  wire logic [7:0]               mouse_buttons,
	input  wire logic                     in_game,
	input  wire logic                     shot_on,
	output logic                          start_game_signal,
	output logic                          duck_kill_signal
);

	logic               in_button;
	logic signed [11:0] cur_x;
	logic signed [11:0] cur_y;
	logic signed [11:0] duck_x;
	logic signed [11:0] duck_y;
	logic               in_box;

	// ------------------------------
	// main menu start click
	assign in_button = (cursor.x >= `MENU_BTN_X0) && (cursor.x <= `MENU_BTN_X1) &&
		(cursor.y >= `MENU_BTN_Y0) && (cursor.y <= `MENU_BTN_Y1);

	assign start_game_signal = in_button && (mouse_buttons == `BTN_LEFT) && !in_game;

	// ------------------------------
	// duck hit box, signed so negative duck positions work
	assign cur_x  = $signed({2'b00, cursor.x});
	assign cur_y  = $signed({2'b00, cursor.y});
	assign duck_x = duck.x;   // sign extended
	assign duck_y = duck.y;

	assign in_box = (cur_x > duck_x - 12'(`HIT_MARGIN_LO)) &&
		(cur_x < duck_x + 12'(`HIT_MARGIN_HI)) &&
		(cur_y > duck_y - 12'(`HIT_MARGIN_LO)) &&
		(cur_y < duck_y + 12'(`HIT_MARGIN_HI));

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
			duck_kill_signal <= 1'b0;
		else
			duck_kill_signal <= shot_on && in_box;
	end

endmodule

`default_nettype wire

// ==== src/hud_overlay.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module hud_overlay (
	input  wire duck_hunt_pkg::beam_t   beam,
	input  wire logic [1:0]             count,
	input  wire logic [`NUM_DUCKS-1:0]  duck_killed,
	input  wire logic                   in_game,
	output logic                        square_on,
	output duck_hunt_pkg::tally_mark_e  tally
);

	logic sq1_on;
	logic sq2_on;
	logic sq3_on;
	logic in_band;

	// one shots-left square, left edge x0
	function automatic logic in_square(
		input logic [`COORD_W-1:0] x,
		input logic [`COORD_W-1:0] y,
		input int                  x0
	);
		return (int'(x) >= x0) && (int'(x) < x0 + `SQ_W) &&
			(y >= `SQ_Y0) && (y <= `SQ_Y1);
	endfunction

	// ------------------------------
	// shots left, right square goes first
	assign sq1_on = in_square(beam.draw_x, beam.draw_y, `SQ1_X0) && (count <= 2'd2);
	assign sq2_on = in_square(beam.draw_x, beam.draw_y, `SQ2_X0) && (count <= 2'd1);
	assign sq3_on = in_square(beam.draw_x, beam.draw_y, `SQ3_X0) && (count == 2'd0);

	assign square_on = in_game && (sq1_on || sq2_on || sq3_on);

	// ------------------------------
	// tally row
	assign in_band = (beam.draw_x >= `TALLY_BAND_X0) && (beam.draw_x <= `TALLY_BAND_X1) &&
		(beam.draw_y >= `TALLY_BAND_Y0) && (beam.draw_y <= `TALLY_BAND_Y1);

	always_comb
	begin : tally_proc
		int dx;
		int dy;

		tally = duck_hunt_pkg::TALLY_NONE;
		dx    = 0;
		dy    = int'(beam.draw_y) - `TALLY_Y;   // same row for every disc

		if (in_game && in_band)
		begin
			for (int i = 0; i < `NUM_DUCKS; i++)
			begin
				dx = int'(beam.draw_x) - (`TALLY_X0 + i * `TALLY_PITCH);
				// discs never overlap so at most one matches
				if (dx * dx + dy * dy <= `TALLY_R2)
				begin
					if (duck_killed[i])
						tally = duck_hunt_pkg::TALLY_HIT;
					else
						tally = duck_hunt_pkg::TALLY_MISS;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/pixel_compositor.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module pixel_compositor (
	input  wire logic                       vga_clk,
	input  wire logic                       Reset,
	input  wire duck_hunt_pkg::beam_t       beam,
	input  wire duck_hunt_pkg::cursor_t     cursor,
	input  wire logic                       shot_on,
	input  wire logic                       square_on,
	input  wire duck_hunt_pkg::tally_mark_e tally,
	output duck_hunt_pkg::rgb_t             pixel
);

	int                  dist_x;
	int                  dist_y;
	int                  abs_x;
	int                  abs_y;
	logic                cursor_on;
	logic                flash_box;
	duck_hunt_pkg::rgb_t pixel_next;

	// ------------------------------
	// distance from cursor centre
	assign dist_x = int'(beam.draw_x) - int'(cursor.x);
	assign dist_y = int'(beam.draw_y) - int'(cursor.y);
	assign abs_x  = (dist_x < 0) ? -dist_x : dist_x;
	assign abs_y  = (dist_y < 0) ? -dist_y : dist_y;

	assign cursor_on = (abs_x + abs_y) <= int'(cursor.size);   // diamond
	assign flash_box = (abs_x <= `FLASH_HALF) && (abs_y <= `FLASH_HALF);

	// ------------------------------
	// priority select
	always_comb
	begin
		if (!beam.visible)
			pixel_next = '0;
		else if (shot_on)
		begin
			// light-gun frame, only the target area is bright
			if (flash_box)
				pixel_next = duck_hunt_pkg::rgb_t'(`COL_WHITE);
			else
				pixel_next = '0;
		end
		else if (cursor_on)
			pixel_next = duck_hunt_pkg::rgb_t'(`COL_WHITE);
		else if (square_on)
			pixel_next = duck_hunt_pkg::rgb_t'(`COL_SHOT);
		else if (tally == duck_hunt_pkg::TALLY_HIT)
			pixel_next = duck_hunt_pkg::rgb_t'(`COL_HIT);
		else if (tally == duck_hunt_pkg::TALLY_MISS)
			pixel_next = duck_hunt_pkg::rgb_t'(`COL_WHITE);
		else
			pixel_next = duck_hunt_pkg::rgb_t'(`COL_BG);   // flat sky
	end

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
			pixel <= '0;
		else
			pixel <= pixel_next;
	end

	// blanking must reach the DAC one cycle later
	a_blank_black: assert property (@(posedge vga_clk) disable iff (Reset)
		!beam.visible |=> (pixel == '0))
		else $error("pixel not black after blanking");

endmodule

`default_nettype wire

// ==== src/trigger_tracker.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module trigger_tracker (
	input  wire logic       vga_clk,
	input  wire logic       Reset,
	input  wire logic [7:0] mouse_buttons,
	input  wire logic       shoot_enable,
	input  wire logic       kill_pending,
	input  wire logic       out_of_shots,
	output logic            shot_on,
	output logic [1:0]      count,
	output logic [9:0]      ledr
);

	logic                   trigger;     // right button held
	logic                   press;       // registered trigger
	logic                   press_d;
	logic                   shot_latch;  // flash timed out, held until release
	logic [`HOLD_CNT_W-1:0] hold_cnt;
	logic                   count_step;

	assign trigger    = (mouse_buttons == `BTN_RIGHT);
	assign count_step = press & ~press_d;  // first cycle of a press

	// ------------------------------
	// shot flash and bullet count
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			press      <= 1'b0;
			press_d    <= 1'b0;
			shot_latch <= 1'b0;
			shot_on    <= 1'b0;
			hold_cnt   <= '0;
			count      <= 2'd0;
		end
		else
		begin
			press_d <= press;

			if (trigger)
			begin
				press    <= 1'b1;
				hold_cnt <= hold_cnt + 1'b1;
				if (!shot_latch)
					shot_on <= 1'b1;
				// flash long enough, end it until the trigger is let go
				if (hold_cnt > `HOLD_CNT_W'(`SHOT_FLASH_CYCLES) && !shot_latch)
				begin
					shot_on    <= 1'b0;
					hold_cnt   <= '0;
					shot_latch <= 1'b1;
				end
			end
			else
			begin
				press      <= 1'b0;
				hold_cnt   <= '0;
				shot_latch <= 1'b0;
				shot_on    <= 1'b0;
			end

			// spent bullets
			if (count_step && count < 2'(`MAX_SHOTS) && shoot_enable)
			begin
				count      <= count + 2'd1;
				shot_latch <= 1'b0;   // new bullet rearms the flash
			end
			else if (kill_pending || out_of_shots)
				count <= 2'd0;        // round over, reload
		end
	end

	// debug word for the board LEDs
	assign ledr = {shot_on, shot_latch, hold_cnt[7:0]};

	// ------------------------------
	// checks
	// full magazine stays full until the round is cleared
	a_count_max: assert property (@(posedge vga_clk) disable iff (Reset)
		(count == 2'(`MAX_SHOTS)) && !kill_pending && !out_of_shots
		|=> (count == 2'(`MAX_SHOTS)))
		else $error("bullet count wrapped past the limit");

	a_shot_needs_press: assert property (@(posedge vga_clk) disable iff (Reset)
		shot_on |-> $past(trigger))
		else $error("shot flash without a trigger press");

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
`default_nettype none

module clock_gen (
	output logic vga_clk,
	output logic Reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		vga_clk = 1'b0;
		forever #5 vga_clk = ~vga_clk;   // 10 ns period
	end

	// reset held for 16 rising edges
	initial
	begin
		Reset = 1'b1;
		repeat (16) @(posedge vga_clk);
		Reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/tb_color_mapper.sv ====
`default_nettype none
`include "duck_hunt_macros.svh"

module tb_color_mapper;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RUN_CYCLES = 20 + 4 * 130 + 200 + (`SHOT_FLASH_CYCLES + 300) + 200 + 200;
	localparam longint WATCHDOG_NS = longint'(RUN_CYCLES) * 12 / 10 * 10;

	logic                       vga_clk;
	logic                       Reset;
	duck_hunt_pkg::beam_t       beam;
	duck_hunt_pkg::cursor_t     cursor;
	logic [7:0]                 mouse_buttons;
	duck_hunt_pkg::duck_pos_t   duck;
	logic [`NUM_DUCKS-1:0]      duck_killed;
	duck_hunt_pkg::game_flags_t flags;
	duck_hunt_pkg::rgb_t        pixel;
	logic [1:0]                 count;
	logic [9:0]                 ledr;
	logic                       start_game_signal;
	logic                       duck_kill_signal;

	int n_checks = 0;
	int n_errors = 0;
	int vis_pct  = 90;   // chance of a visible beam pixel

	clock_gen i_clock_gen (.vga_clk(vga_clk), .Reset(Reset));

	color_mapper i_dut (
		.vga_clk(vga_clk), .Reset(Reset), .beam(beam), .cursor(cursor),
		.mouse_buttons(mouse_buttons), .duck(duck), .duck_killed(duck_killed),
		.flags(flags), .pixel(pixel), .count(count), .ledr(ledr),
		.start_game_signal(start_game_signal), .duck_kill_signal(duck_kill_signal)
	);

	// ------------------------------
	// compare tasks
	task automatic check_rgb(input string name, input duck_hunt_pkg::rgb_t exp,
		input duck_hunt_pkg::rgb_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input logic [1:0] exp, input logic [1:0] act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_ledr(input string name, input logic [9:0] exp, input logic [9:0] act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// expected colour of one pixel
	function automatic duck_hunt_pkg::rgb_t ref_pixel(input duck_hunt_pkg::beam_t b,
		input duck_hunt_pkg::cursor_t c, input logic [1:0] cnt, input logic shot,
		input logic in_game, input logic [`NUM_DUCKS-1:0] killed);
		int x;
		int y;
		int ax;
		int ay;
		int dx;
		logic sq;
		x  = int'(b.draw_x);
		y  = int'(b.draw_y);
		ax = (x > int'(c.x)) ? x - int'(c.x) : int'(c.x) - x;
		ay = (y > int'(c.y)) ? y - int'(c.y) : int'(c.y) - y;
		if (!b.visible)
			return 12'h000;
		if (shot)
			return (ax <= `FLASH_HALF && ay <= `FLASH_HALF) ? 12'hFFF : 12'h000;
		if (ax + ay <= int'(c.size))
			return 12'hFFF;
		sq = 0;
		if (y >= `SQ_Y0 && y <= `SQ_Y1)
		begin
			sq = (x >= `SQ1_X0 && x <= `SQ1_X0 + 8 && cnt <= 2) ||
				(x >= `SQ2_X0 && x <= `SQ2_X0 + 8 && cnt <= 1) ||
				(x >= `SQ3_X0 && x <= `SQ3_X0 + 8 && cnt == 0);
		end
		if (in_game && sq)
			return 12'hAAA;
		if (in_game && x >= 200 && x <= 433 && y >= 417 && y <= 431)
		begin
			for (int i = 0; i < `NUM_DUCKS; i++)
			begin
				dx = x - (228 + 22 * i);
				if (dx * dx + (y - 424) * (y - 424) <= 36)
					return killed[i] ? 12'hD00 : 12'hFFF;
			end
		end
		return 12'hBBB;
	endfunction

	// ------------------------------
	// random beam, one pixel per cycle
	always @(posedge vga_clk)
	begin
		int r;
		int bx;
		int by;
		r = $urandom % 4;
		case (r)
			0:
			begin
				bx = $urandom % 640;
				by = $urandom % 480;
			end
			1:
			begin
				bx = 60 + $urandom % 60;
				by = 410 + $urandom % 28;
			end
			2:
			begin
				bx = 195 + $urandom % 245;
				by = 412 + $urandom % 24;
			end
			default:
			begin
				bx = int'(cursor.x) + 30 - $urandom % 61;   // around the cursor
				by = int'(cursor.y) + 30 - $urandom % 61;
			end
		endcase
		if (bx < 0)
			bx = 0;
		if (by < 0)
			by = 0;
		beam <= {10'(bx), 10'(by), 1'(($urandom % 100) < vis_pct)};
	end

	// ------------------------------
	// shot_on model and pixel compare
	logic                   m_shot  = 0;
	logic                   m_latch = 0;
	int                     m_hold  = 0;
	logic                   cap_valid = 0;
	duck_hunt_pkg::beam_t   cap_beam;
	duck_hunt_pkg::cursor_t cap_cursor;
	logic [1:0]             cap_count;
	logic                   cap_shot;
	logic                   cap_game;
	logic [`NUM_DUCKS-1:0]  cap_killed;

	always @(posedge vga_clk)
	begin
		if (!Reset)
		begin
			cap_beam   = beam;   // values before this edge
			cap_cursor = cursor;
			cap_count  = count;
			cap_shot   = m_shot;
			cap_game   = flags.in_game;
			cap_killed = duck_killed;
			cap_valid  = 1;
			if (mouse_buttons == 8'd2)
			begin
				if (!m_latch)
					m_shot = 1;
				if (m_hold > `SHOT_FLASH_CYCLES && !m_latch)
				begin
					m_shot  = 0;
					m_latch = 1;
					m_hold  = 0;
				end
				else
					m_hold++;
			end
			else
			begin
				m_shot  = 0;
				m_latch = 0;
				m_hold  = 0;
			end
		end
	end

	always @(negedge vga_clk)
	begin
		if (cap_valid)
			check_rgb("pixel", ref_pixel(cap_beam, cap_cursor, cap_count, cap_shot,
				cap_game, cap_killed), pixel);
	end

	// ------------------------------
	// stimulus helpers
	task automatic fire(input int len);
		@(posedge vga_clk) mouse_buttons <= `BTN_RIGHT;
		repeat (len) @(posedge vga_clk);
		mouse_buttons <= 8'd0;
		repeat (3) @(posedge vga_clk);
	endtask

	task automatic press_and_count(input string name, input logic se);
		logic [1:0] old;
		@(posedge vga_clk) flags.shoot_enable <= se;
		@(negedge vga_clk) old = count;
		@(posedge vga_clk) mouse_buttons <= `BTN_RIGHT;
		@(posedge vga_clk);
		@(negedge vga_clk) check_count({name, " early"}, old, count);
		@(posedge vga_clk);
		@(negedge vga_clk) check_count(name, (se && old < 3) ? old + 2'd1 : old, count);
		@(posedge vga_clk) mouse_buttons <= 8'd0;
		repeat (3) @(posedge vga_clk);
	endtask

	task automatic hit_case(input int dux, input int duy, input int cx, input int cy,
		input logic shot);
		logic exp;
		exp = shot && (cx - dux > -18) && (cx - dux < 83) && (cy - duy > -18) && (cy - duy < 83);
		@(posedge vga_clk);
		cursor.x <= 10'(cx);
		cursor.y <= 10'(cy);
		duck     <= {11'(dux), 11'(duy)};
		@(posedge vga_clk);
		@(negedge vga_clk) check_bit($sformatf("kill duck %0d,%0d cursor %0d,%0d", dux, duy, cx, cy),
			exp, duck_kill_signal);
	endtask

	task automatic report(input string name, input int errs_before);
		$display("test %s done, %0d errors", name, n_errors - errs_before);
	endtask

	// ------------------------------
	// watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		int e;
		int n;
		int xs[4];
		int ys[4];
		xs = '{199, 200, 300, 301};
		ys = '{249, 250, 300, 301};
		void'($urandom(43141));
		cursor        = {10'd320, 10'd240, 10'd4};
		mouse_buttons = 8'd0;
		duck          = '0;
		duck_killed   = '0;
		flags         = '0;
		beam          = '0;
		@(negedge vga_clk);
		check_rgb("reset pixel", 12'h000, pixel);   // still in reset
		wait (Reset === 1'b0);
		repeat (2) @(posedge vga_clk);

		// reset values and blanking
		e = n_errors;
		@(negedge vga_clk);
		check_count("reset count", 2'd0, count);
		check_bit("reset kill", 1'b0, duck_kill_signal);
		check_bit("reset ledr9", 1'b0, ledr[9]);
		vis_pct = 0;
		repeat (10) @(posedge vga_clk);
		vis_pct <= 90;
		report("reset_blank", e);

		// random pixels, one round per count value
		e = n_errors;
		flags.shoot_enable <= 1'b1;
		for (int r = 0; r < 4; r++)
		begin
			repeat (110)
			begin
				@(posedge vga_clk);
				cursor      <= {10'($urandom % 640), 10'($urandom % 480), 10'($urandom % 16)};
				duck_killed <= `NUM_DUCKS'($urandom);
				flags.in_game <= 1'($urandom);
			end
			fire(2);
		end
		report("random_pixels", e);

		// trigger and bullet counter
		e = n_errors;
		flags.in_game <= 1'b1;
		@(posedge vga_clk) flags.kill_pending <= 1'b1;
		@(posedge vga_clk) flags.kill_pending <= 1'b0;
		for (int i = 0; i < 4; i++)
			press_and_count($sformatf("count press %0d", i), 1'b1);
		@(posedge vga_clk) flags.kill_pending <= 1'b1;
		@(posedge vga_clk) flags.kill_pending <= 1'b0;
		@(negedge vga_clk) check_count("count kill clear", 2'd0, count);
		press_and_count("count disabled", 1'b0);
		press_and_count("count after clear", 1'b1);
		@(posedge vga_clk) flags.out_of_shots <= 1'b1;
		@(posedge vga_clk) flags.out_of_shots <= 1'b0;
		@(negedge vga_clk) check_count("count out clear", 2'd0, count);
		report("trigger_count", e);

		// shot flash, held to timeout then a short press
		e = n_errors;
		flags.shoot_enable <= 1'b0;
		cursor <= {10'd320, 10'd240, 10'd5};
		@(posedge vga_clk) mouse_buttons <= `BTN_RIGHT;
		n = 0;
		do
		begin
			@(negedge vga_clk);
			n++;
		end
		while (ledr[9] !== 1'b1 && n < 5);
		check_ledr("flash start", {1'b1, 1'b0, 8'd1}, ledr);   // first held cycle
		while (ledr[9] === 1'b1 && n <= `SHOT_FLASH_CYCLES + 3)
		begin
			@(negedge vga_clk);
			n++;
		end
		check_bit("flash timeout end", 1'b0, ledr[9]);
		check_bit("flash latch set", 1'b1, ledr[8]);
		@(posedge vga_clk) mouse_buttons <= 8'd0;
		repeat (3) @(posedge vga_clk);
		fire(40);
		@(negedge vga_clk) check_ledr("flash release end", 10'd0, ledr);
		report("shot_flash", e);

		// start click at the button edges
		e = n_errors;
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 4; j++)
				for (int g = 0; g < 2; g++)
					for (int b = 1; b <= 2; b++)
					begin
						@(posedge vga_clk);
						cursor.x      <= 10'(xs[i]);
						cursor.y      <= 10'(ys[j]);
						flags.in_game <= 1'(g);
						mouse_buttons <= 8'(b);
						@(negedge vga_clk) check_bit($sformatf("start %0d,%0d game %0d btn %0d",
							xs[i], ys[j], g, b), (xs[i] >= 200 && xs[i] <= 300 &&
							ys[j] >= 250 && ys[j] <= 300 && b == 1 && g == 0),
							start_game_signal);
					end
		@(posedge vga_clk) mouse_buttons <= 8'd0;
		repeat (3) @(posedge vga_clk);
		report("start_click", e);

		// duck hit box margins, trigger held
		e = n_errors;
		hit_case(100, 100, 110, 110, 1'b0);
		@(posedge vga_clk) mouse_buttons <= `BTN_RIGHT;
		repeat (2) @(posedge vga_clk);
		foreach (xs[i])
		begin
			hit_case(100, 100, 100 + (i < 2 ? i - 18 : i + 80), 120, 1'b1);
			hit_case(100, 100, 120, 100 + (i < 2 ? i - 18 : i + 80), 1'b1);
		end
		hit_case(-82, -50, 0, 10, 1'b1);
		hit_case(-83, -50, 0, 10, 1'b1);
		hit_case(-30, -82, 20, 0, 1'b1);
		hit_case(-30, -83, 20, 0, 1'b1);
		@(posedge vga_clk) mouse_buttons <= 8'd0;
		repeat (3) @(posedge vga_clk);
		report("duck_hit", e);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
